//--- design/la32r_pkg.sv
`default_nettype none

package la32r_pkg;

    // machine word and register number
    localparam int reg_w      = 32;
    localparam int reg_addr_w = 5;

    typedef logic [reg_w-1:0]      word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // opcode field widths, one per format
    typedef logic [16:0] op3r_t;
    typedef logic [9:0]  op2ri12_t;
    typedef logic [6:0]  op1rsi20_t;
    typedef logic [5:0]  op2ri16_t;
    typedef logic [5:0]  opi26_t;

    // 3r and 2rui5, inst[31:15]
    localparam op3r_t op_add_w  = 17'h00020;
    localparam op3r_t op_sub_w  = 17'h00022;
    localparam op3r_t op_slt    = 17'h00024;
    localparam op3r_t op_sltu   = 17'h00025;
    localparam op3r_t op_nor    = 17'h00028;
    localparam op3r_t op_and    = 17'h00029;
    localparam op3r_t op_or     = 17'h0002a;
    localparam op3r_t op_xor    = 17'h0002b;
    localparam op3r_t op_sll_w  = 17'h0002e;
    localparam op3r_t op_srl_w  = 17'h0002f;
    localparam op3r_t op_sra_w  = 17'h00030;
    localparam op3r_t op_slli_w = 17'h00081;
    localparam op3r_t op_srli_w = 17'h00089;
    localparam op3r_t op_srai_w = 17'h00091;

    // 2ri12, inst[31:22]
    localparam op2ri12_t op_slti   = 10'h008;
    localparam op2ri12_t op_sltui  = 10'h009;
    localparam op2ri12_t op_addi_w = 10'h00a;
    localparam op2ri12_t op_andi   = 10'h00d;
    localparam op2ri12_t op_ori    = 10'h00e;
    localparam op2ri12_t op_xori   = 10'h00f;

    // 1rsi20, inst[31:25]
    localparam op1rsi20_t op_lu12i_w   = 7'h0a;
    localparam op1rsi20_t op_pcaddu12i = 7'h0e;

    // jumps and branches, inst[31:26]
    localparam op2ri16_t op_jirl = 6'h13;
    localparam opi26_t   op_b    = 6'h14;
    localparam opi26_t   op_bl   = 6'h15;
    localparam op2ri16_t op_beq  = 6'h16;
    localparam op2ri16_t op_bne  = 6'h17;
    localparam op2ri16_t op_blt  = 6'h18;
    localparam op2ri16_t op_bge  = 6'h19;
    localparam op2ri16_t op_bltu = 6'h1a;
    localparam op2ri16_t op_bgeu = 6'h1b;

    // BL always links into r1
    localparam reg_addr_t link_reg = 5'd1;

    // shift immediates reuse this layout, ui5 sits in rk
    typedef struct packed {
        op3r_t     op;
        reg_addr_t rk;
        reg_addr_t rj;
        reg_addr_t rd;
    } fmt_3r_s;

    typedef struct packed {
        op2ri12_t    op;
        logic [11:0] i12;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri12_s;

    typedef struct packed {
        op1rsi20_t   op;
        logic [19:0] si20;
        reg_addr_t   rd;
    } fmt_1rsi20_s;

    typedef struct packed {
        op2ri16_t    op;
        logic [15:0] i16;
        reg_addr_t   rj;
        reg_addr_t   rd;
    } fmt_2ri16_s;

    // offs26 is split, low half first
    typedef struct packed {
        opi26_t      op;
        logic [15:0] offs_lo;
        logic [9:0]  offs_hi;
    } fmt_i26_s;

    // one fetched word, read through whichever format matches
    typedef union packed {
        fmt_3r_s     r3;
        fmt_2ri12_s  ri12;
        fmt_1rsi20_s rsi20;
        fmt_2ri16_s  ri16;
        fmt_i26_s    i26;
    } inst_u;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_slt, alu_sltu,
        alu_and, alu_nor, alu_or, alu_xor,
        alu_sll, alu_srl, alu_sra, alu_lui
    } alu_op_e;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        word_t     a;
        word_t     b;
        reg_addr_t dest;
        logic      we;
    } dec_ex_s;

    typedef struct packed {
        logic      valid;
        reg_addr_t dest;
        logic      we;
        word_t     result;
    } ex_wb_s;

endpackage

`default_nettype wire

//--- design/la32r_decode.sv
`default_nettype none

module la32r_decode (
    input  wire logic                inst_valid_i,
    input  wire la32r_pkg::inst_u    inst_i,
    input  wire la32r_pkg::word_t    pc_i,
    input  wire la32r_pkg::word_t    rj_data_i,
    input  wire la32r_pkg::word_t    rk_data_i,
    input  wire la32r_pkg::reg_addr_t ex_dest_i,
    input  wire la32r_pkg::reg_addr_t wb_dest_i,
    input  wire logic                ex_we_i,
    input  wire logic                wb_we_i,
    output la32r_pkg::reg_addr_t     rj_addr_o,
    output la32r_pkg::reg_addr_t     rk_addr_o,
    output logic                     accept_o,
    output logic                     branch_taken_o,
    output la32r_pkg::word_t         branch_target_o,
    output la32r_pkg::dec_ex_s       dec_o
);

    logic is_add_w, is_sub_w, is_slt, is_sltu, is_nor, is_and, is_or, is_xor;
    logic is_sll_w, is_srl_w, is_sra_w, is_slli_w, is_srli_w, is_srai_w;
    logic is_slti, is_sltui, is_addi_w, is_andi, is_ori, is_xori;
    logic is_lu12i_w, is_pcaddu12i;
    logic is_jirl, is_b, is_bl, is_beq, is_bne, is_blt, is_bge, is_bltu, is_bgeu;
    logic alu_rr, shf_imm, imm_sign12, imm_zero, imm_si20, j_link, cond_br, j_taken;
    logic writes, uses_rj, uses_rk, rj_hazard, rk_hazard, br_taken;
    logic rj_eq_rk, rj_lt_rk, rj_ltu_rk;
    la32r_pkg::reg_addr_t dest;
    la32r_pkg::word_t     offs16, offs26, target;
    la32r_pkg::alu_op_e   alu_op;

    // 17-bit opcode for 3r and shift-immediate forms
    assign is_add_w  = inst_i.r3.op == la32r_pkg::op_add_w;
    assign is_sub_w  = inst_i.r3.op == la32r_pkg::op_sub_w;
    assign is_slt    = inst_i.r3.op == la32r_pkg::op_slt;
    assign is_sltu   = inst_i.r3.op == la32r_pkg::op_sltu;
    assign is_nor    = inst_i.r3.op == la32r_pkg::op_nor;
    assign is_and    = inst_i.r3.op == la32r_pkg::op_and;
    assign is_or     = inst_i.r3.op == la32r_pkg::op_or;
    assign is_xor    = inst_i.r3.op == la32r_pkg::op_xor;
    assign is_sll_w  = inst_i.r3.op == la32r_pkg::op_sll_w;
    assign is_srl_w  = inst_i.r3.op == la32r_pkg::op_srl_w;
    assign is_sra_w  = inst_i.r3.op == la32r_pkg::op_sra_w;
    assign is_slli_w = inst_i.r3.op == la32r_pkg::op_slli_w;
    assign is_srli_w = inst_i.r3.op == la32r_pkg::op_srli_w;
    assign is_srai_w = inst_i.r3.op == la32r_pkg::op_srai_w;

    // 10-bit opcode for 12-bit immediate forms
    assign is_slti   = inst_i.ri12.op == la32r_pkg::op_slti;
    assign is_sltui  = inst_i.ri12.op == la32r_pkg::op_sltui;
    assign is_addi_w = inst_i.ri12.op == la32r_pkg::op_addi_w;
    assign is_andi   = inst_i.ri12.op == la32r_pkg::op_andi;
    assign is_ori    = inst_i.ri12.op == la32r_pkg::op_ori;
    assign is_xori   = inst_i.ri12.op == la32r_pkg::op_xori;

    assign is_lu12i_w   = inst_i.rsi20.op == la32r_pkg::op_lu12i_w;
    assign is_pcaddu12i = inst_i.rsi20.op == la32r_pkg::op_pcaddu12i;

    // 6-bit opcode for jumps and branches
    assign is_jirl = inst_i.ri16.op == la32r_pkg::op_jirl;
    assign is_b    = inst_i.i26.op == la32r_pkg::op_b;
    assign is_bl   = inst_i.i26.op == la32r_pkg::op_bl;
    assign is_beq  = inst_i.ri16.op == la32r_pkg::op_beq;
    assign is_bne  = inst_i.ri16.op == la32r_pkg::op_bne;
    assign is_blt  = inst_i.ri16.op == la32r_pkg::op_blt;
    assign is_bge  = inst_i.ri16.op == la32r_pkg::op_bge;
    assign is_bltu = inst_i.ri16.op == la32r_pkg::op_bltu;
    assign is_bgeu = inst_i.ri16.op == la32r_pkg::op_bgeu;

    // instruction classes
    assign alu_rr = is_add_w | is_sub_w | is_slt | is_sltu | is_nor | is_and
                  | is_or | is_xor | is_sll_w | is_srl_w | is_sra_w;
    assign shf_imm    = is_slli_w | is_srli_w | is_srai_w;
    assign imm_sign12 = is_slti | is_sltui | is_addi_w;
    assign imm_zero   = is_andi | is_ori | is_xori;
    assign imm_si20   = is_lu12i_w | is_pcaddu12i;
    assign j_link     = is_bl | is_jirl;
    assign j_taken    = is_jirl | is_b | is_bl;
    assign cond_br    = is_beq | is_bne | is_blt | is_bge | is_bltu | is_bgeu;

    // unknown opcodes land in none of these so they neither write nor stall
    assign writes  = alu_rr | shf_imm | imm_sign12 | imm_zero | imm_si20 | j_link;
    assign uses_rj = alu_rr | shf_imm | imm_sign12 | imm_zero | is_jirl | cond_br;
    assign uses_rk = alu_rr | cond_br;

    // branches compare rj with rd fetched through the rk port
    assign rj_addr_o = inst_i.r3.rj;
    assign rk_addr_o = cond_br ? inst_i.r3.rd : inst_i.r3.rk;

    assign dest = is_bl ? la32r_pkg::link_reg : inst_i.r3.rd;

    // result stage still counts since its write lands at the end of the cycle
    assign rj_hazard = uses_rj && rj_addr_o != '0
                    && ((ex_we_i && ex_dest_i == rj_addr_o)
                     || (wb_we_i && wb_dest_i == rj_addr_o));
    assign rk_hazard = uses_rk && rk_addr_o != '0
                    && ((ex_we_i && ex_dest_i == rk_addr_o)
                     || (wb_we_i && wb_dest_i == rk_addr_o));

    assign accept_o = inst_valid_i && !rj_hazard && !rk_hazard;

    // offsets are word counts
    assign offs16 = {{14{inst_i.ri16.i16[15]}}, inst_i.ri16.i16, 2'b00};
    assign offs26 = {{4{inst_i.i26.offs_hi[9]}}, inst_i.i26.offs_hi,
                     inst_i.i26.offs_lo, 2'b00};

    assign rj_eq_rk  = rj_data_i == rk_data_i;
    assign rj_lt_rk  = $signed(rj_data_i) < $signed(rk_data_i);
    assign rj_ltu_rk = rj_data_i < rk_data_i;

    assign br_taken = (is_beq & rj_eq_rk) | (is_bne & ~rj_eq_rk)
                    | (is_blt & rj_lt_rk) | (is_bge & ~rj_lt_rk)
                    | (is_bltu & rj_ltu_rk) | (is_bgeu & ~rj_ltu_rk);

    // jirl is register relative while b and bl use offs26
    assign target = is_jirl ? rj_data_i + offs16
                  : (is_b | is_bl) ? pc_i + offs26
                  : pc_i + offs16;

    // both outputs quiet unless this cycle accepts
    assign branch_taken_o  = accept_o && (j_taken || br_taken);
    assign branch_target_o = branch_taken_o ? target : '0;

    always_comb begin
        alu_op = la32r_pkg::alu_add;
        if (is_sub_w) begin
            alu_op = la32r_pkg::alu_sub;
        end else if (is_slt | is_slti) begin
            alu_op = la32r_pkg::alu_slt;
        end else if (is_sltu | is_sltui) begin
            alu_op = la32r_pkg::alu_sltu;
        end else if (is_and | is_andi) begin
            alu_op = la32r_pkg::alu_and;
        end else if (is_nor) begin
            alu_op = la32r_pkg::alu_nor;
        end else if (is_or | is_ori) begin
            alu_op = la32r_pkg::alu_or;
        end else if (is_xor | is_xori) begin
            alu_op = la32r_pkg::alu_xor;
        end else if (is_sll_w | is_slli_w) begin
            alu_op = la32r_pkg::alu_sll;
        end else if (is_srl_w | is_srli_w) begin
            alu_op = la32r_pkg::alu_srl;
        end else if (is_sra_w | is_srai_w) begin
            alu_op = la32r_pkg::alu_sra;
        end else if (is_lu12i_w) begin
            alu_op = la32r_pkg::alu_lui;
        end
    end

    always_comb begin
        dec_o.valid  = accept_o;
        dec_o.alu_op = alu_op;
        dec_o.dest   = dest;
        // r0 writes are dropped here so later stages never see them
        dec_o.we     = accept_o && writes && dest != '0;
        // links and pcaddu12i add to the pc
        dec_o.a      = (j_link | is_pcaddu12i) ? pc_i : rj_data_i;
        if (j_link) begin
            dec_o.b = 32'd4;
        end else if (imm_zero) begin
            dec_o.b = {20'd0, inst_i.ri12.i12};
        end else if (imm_sign12) begin
            dec_o.b = {{20{inst_i.ri12.i12[11]}}, inst_i.ri12.i12};
        end else if (imm_si20) begin
            dec_o.b = {inst_i.rsi20.si20, 12'd0};
        end else if (shf_imm) begin
            // ui5 sits in the rk field
            dec_o.b = {27'd0, inst_i.r3.rk};
        end else begin
            dec_o.b = rk_data_i;
        end
    end

endmodule

`default_nettype wire

//--- design/la32r_execute.sv
`default_nettype none

module la32r_execute (
    input  wire logic              clk,
    input  wire logic              reset_i,
    input  wire la32r_pkg::dec_ex_s dec_i,
    output la32r_pkg::ex_wb_s      ex_o,
    output la32r_pkg::reg_addr_t   ex_dest_o,
    output logic                   ex_we_o
);

    la32r_pkg::dec_ex_s dec_q;
    la32r_pkg::word_t   result;
    logic [4:0]         shamt;

    // stage register, a bubble simply flows in when decode stalls
    always_ff @(posedge clk) begin
        if (reset_i) begin
            dec_q.valid <= 1'b0;
            dec_q.we    <= 1'b0;
        end else begin
            dec_q <= dec_i;
        end
    end

    // shifts only look at the low five bits
    assign shamt = dec_q.b[4:0];

    always_comb begin
        unique case (dec_q.alu_op)
            la32r_pkg::alu_add:  result = dec_q.a + dec_q.b;
            la32r_pkg::alu_sub:  result = dec_q.a - dec_q.b;
            la32r_pkg::alu_slt:  result = {31'd0, $signed(dec_q.a) < $signed(dec_q.b)};
            la32r_pkg::alu_sltu: result = {31'd0, dec_q.a < dec_q.b};
            la32r_pkg::alu_and:  result = dec_q.a & dec_q.b;
            la32r_pkg::alu_nor:  result = ~(dec_q.a | dec_q.b);
            la32r_pkg::alu_or:   result = dec_q.a | dec_q.b;
            la32r_pkg::alu_xor:  result = dec_q.a ^ dec_q.b;
            la32r_pkg::alu_sll:  result = dec_q.a << shamt;
            la32r_pkg::alu_srl:  result = dec_q.a >> shamt;
            la32r_pkg::alu_sra:  result = $signed(dec_q.a) >>> shamt;
            // lu12i, already shifted by decode
            la32r_pkg::alu_lui:  result = dec_q.b;
            default:             result = dec_q.a + dec_q.b;
        endcase
    end

    always_comb begin
        ex_o.valid  = dec_q.valid;
        ex_o.dest   = dec_q.dest;
        ex_o.we     = dec_q.we;
        ex_o.result = result;
    end

    // pending dest, fed back to the decode hazard check
    assign ex_dest_o = dec_q.dest;
    assign ex_we_o   = dec_q.we;

    // decode must have filtered out invalid and r0 writes
    a_we_clean: assert property (@(posedge clk) disable iff (reset_i)
        dec_q.we |-> dec_q.valid && dec_q.dest != '0)
        else $error("execute holds a write to r0 or an invalid write");

endmodule

`default_nettype wire

//--- design/la32r_writeback.sv
`default_nettype none

module la32r_writeback (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire la32r_pkg::ex_wb_s    ex_i,
    input  wire la32r_pkg::reg_addr_t rj_addr_i,
    input  wire la32r_pkg::reg_addr_t rk_addr_i,
    output la32r_pkg::word_t          rj_data_o,
    output la32r_pkg::word_t          rk_data_o,
    output la32r_pkg::reg_addr_t      wb_dest_o,
    output logic                      wb_we_o,
    output logic                      wb_valid_o,
    output la32r_pkg::reg_addr_t      wb_addr_o,
    output la32r_pkg::word_t          wb_data_o
);

    localparam int rf_depth = 2 ** la32r_pkg::reg_addr_w;

    la32r_pkg::ex_wb_s ex_q;
    la32r_pkg::word_t  rf [rf_depth];

    // result stage register
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_q.valid <= 1'b0;
            ex_q.we    <= 1'b0;
        end else begin
            ex_q <= ex_i;
        end
    end

    // write lands at the end of the result cycle
    // r0 is never written
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < rf_depth; i++) begin
                rf[i] <= '0;
            end
        end else if (ex_q.we && ex_q.dest != '0) begin
            rf[ex_q.dest] <= ex_q.result;
        end
    end

    // two async read ports with r0 forced to zero
    assign rj_data_o = (rj_addr_i == '0) ? '0 : rf[rj_addr_i];
    assign rk_data_o = (rk_addr_i == '0) ? '0 : rf[rk_addr_i];

    // pending dest for the decode hazard check
    assign wb_dest_o = ex_q.dest;
    assign wb_we_o   = ex_q.we;

    // one strobe per written result
    assign wb_valid_o = ex_q.valid && ex_q.we;
    assign wb_addr_o  = ex_q.dest;
    assign wb_data_o  = ex_q.result;

endmodule

`default_nettype wire

//--- design/la32r_core.sv
`default_nettype none

module la32r_core (
    input  wire logic                 clk,
    input  wire logic                 reset_i,
    input  wire logic                 inst_valid_i,
    input  wire la32r_pkg::word_t     inst_i,
    input  wire la32r_pkg::word_t     pc_i,
    output logic                      inst_accept_o,
    output logic                      branch_taken_o,
    output la32r_pkg::word_t          branch_target_o,
    output logic                      wb_valid_o,
    output la32r_pkg::reg_addr_t      wb_addr_o,
    output la32r_pkg::word_t          wb_data_o
);

    la32r_pkg::dec_ex_s   dec;
    la32r_pkg::ex_wb_s    ex;
    la32r_pkg::reg_addr_t rj_addr, rk_addr;
    la32r_pkg::word_t     rj_data, rk_data;
    la32r_pkg::reg_addr_t ex_dest, wb_dest;
    logic                 ex_we, wb_we;

    // decode, operand read and branch resolve
    la32r_decode u_decode (
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .pc_i            (pc_i),
        .rj_data_i       (rj_data),
        .rk_data_i       (rk_data),
        .ex_dest_i       (ex_dest),
        .wb_dest_i       (wb_dest),
        .ex_we_i         (ex_we),
        .wb_we_i         (wb_we),
        .rj_addr_o       (rj_addr),
        .rk_addr_o       (rk_addr),
        .accept_o        (inst_accept_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .dec_o           (dec)
    );

    la32r_execute u_execute (
        .clk       (clk),
        .reset_i   (reset_i),
        .dec_i     (dec),
        .ex_o      (ex),
        .ex_dest_o (ex_dest),
        .ex_we_o   (ex_we)
    );

    // result stage plus register file
    la32r_writeback u_writeback (
        .clk        (clk),
        .reset_i    (reset_i),
        .ex_i       (ex),
        .rj_addr_i  (rj_addr),
        .rk_addr_i  (rk_addr),
        .rj_data_o  (rj_data),
        .rk_data_o  (rk_data),
        .wb_dest_o  (wb_dest),
        .wb_we_o    (wb_we),
        .wb_valid_o (wb_valid_o),
        .wb_addr_o  (wb_addr_o),
        .wb_data_o  (wb_data_o)
    );

endmodule

`default_nettype wire

//--- sim/la32r_core_tb.sv
`default_nettype none

module la32r_core_tb;

    localparam int num_insts = 500;
    // 6 cycles per instruction at worst plus drain time
    localparam int watchdog_time = num_insts * 6 * 40 + 100 * 40;

    typedef struct packed {
        logic                 writes;
        la32r_pkg::reg_addr_t dest;
        la32r_pkg::word_t     data;
        logic                 taken;
        la32r_pkg::word_t     target;
    } expect_s;

    logic                 clk;
    logic                 reset_i;
    logic                 inst_valid_i;
    la32r_pkg::word_t     inst_i;
    la32r_pkg::word_t     pc_i;
    logic                 inst_accept_o;
    logic                 branch_taken_o;
    la32r_pkg::word_t     branch_target_o;
    logic                 wb_valid_o;
    la32r_pkg::reg_addr_t wb_addr_o;
    la32r_pkg::word_t     wb_data_o;

    // architectural state of the model
    la32r_pkg::word_t arch_rf [32];
    la32r_pkg::word_t pc;
    logic [31:0]      lfsr_state;
    expect_s          cur_exp;
    expect_s          wb_q [$];
    int               due_q [$];
    expect_s          wb_head;
    int               wb_due;
    int               cycle = 0;
    int               issued = 0;

    la32r_core u_dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .inst_valid_i    (inst_valid_i),
        .inst_i          (inst_i),
        .pc_i            (pc_i),
        .inst_accept_o   (inst_accept_o),
        .branch_taken_o  (branch_taken_o),
        .branch_target_o (branch_target_o),
        .wb_valid_o      (wb_valid_o),
        .wb_addr_o       (wb_addr_o),
        .wb_data_o       (wb_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input la32r_pkg::word_t got,
                                   input la32r_pkg::word_t exp);
        stop_with_error($sformatf("FAILED at time %0t: %s is 0x%h, expected 0x%h",
                                  $time, name, got, exp));
    endtask

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    // kinds 0..13 are 3r and shift imm, 14..19 ri12, 20..21 si20 and 22..30 jumps
    function automatic la32r_pkg::word_t encode_inst(input int kind,
            input la32r_pkg::reg_addr_t rd, input la32r_pkg::reg_addr_t rj,
            input la32r_pkg::reg_addr_t rk, input logic [25:0] imm);
        case (kind)
            0:  return {17'h00020, rk, rj, rd};
            1:  return {17'h00022, rk, rj, rd};
            2:  return {17'h00024, rk, rj, rd};
            3:  return {17'h00025, rk, rj, rd};
            4:  return {17'h00028, rk, rj, rd};
            5:  return {17'h00029, rk, rj, rd};
            6:  return {17'h0002a, rk, rj, rd};
            7:  return {17'h0002b, rk, rj, rd};
            8:  return {17'h0002e, rk, rj, rd};
            9:  return {17'h0002f, rk, rj, rd};
            10: return {17'h00030, rk, rj, rd};
            11: return {17'h00081, rk, rj, rd};
            12: return {17'h00089, rk, rj, rd};
            13: return {17'h00091, rk, rj, rd};
            14: return {10'h008, imm[11:0], rj, rd};
            15: return {10'h009, imm[11:0], rj, rd};
            16: return {10'h00a, imm[11:0], rj, rd};
            17: return {10'h00d, imm[11:0], rj, rd};
            18: return {10'h00e, imm[11:0], rj, rd};
            19: return {10'h00f, imm[11:0], rj, rd};
            20: return {7'h0a, imm[19:0], rd};
            21: return {7'h0e, imm[19:0], rd};
            22: return {6'h13, imm[15:0], rj, rd};
            // offs26 low half goes first
            23: return {6'h14, imm[15:0], imm[25:16]};
            24: return {6'h15, imm[15:0], imm[25:16]};
            25: return {6'h16, imm[15:0], rj, rd};
            26: return {6'h17, imm[15:0], rj, rd};
            27: return {6'h18, imm[15:0], rj, rd};
            28: return {6'h19, imm[15:0], rj, rd};
            29: return {6'h1a, imm[15:0], rj, rd};
            default: return {6'h1b, imm[15:0], rj, rd};
        endcase
    endfunction

    // reference model stepping one instruction against arch_rf
    function automatic expect_s model_step(input int kind,
            input la32r_pkg::reg_addr_t rd, input la32r_pkg::reg_addr_t rj,
            input la32r_pkg::reg_addr_t rk, input logic [25:0] imm,
            input la32r_pkg::word_t cur_pc);
        expect_s e;
        la32r_pkg::word_t a, b, c, si12, zi12, off16, off26;
        a = arch_rf[rj];
        b = arch_rf[rk];
        // branches compare rj with rd
        c = arch_rf[rd];
        si12  = {{20{imm[11]}}, imm[11:0]};
        zi12  = {20'd0, imm[11:0]};
        off16 = {{14{imm[15]}}, imm[15:0], 2'b00};
        off26 = {{4{imm[25]}}, imm[25:0], 2'b00};
        e = '0;
        e.writes = 1'b1;
        e.dest = rd;
        case (kind)
            0:  e.data = a + b;
            1:  e.data = a - b;
            2:  e.data = {31'd0, $signed(a) < $signed(b)};
            3:  e.data = {31'd0, a < b};
            4:  e.data = ~(a | b);
            5:  e.data = a & b;
            6:  e.data = a | b;
            7:  e.data = a ^ b;
            8:  e.data = a << b[4:0];
            9:  e.data = a >> b[4:0];
            10: e.data = $signed(a) >>> b[4:0];
            // ui5 is the rk field itself
            11: e.data = a << rk;
            12: e.data = a >> rk;
            13: e.data = $signed(a) >>> rk;
            14: e.data = {31'd0, $signed(a) < $signed(si12)};
            15: e.data = {31'd0, a < si12};
            16: e.data = a + si12;
            17: e.data = a & zi12;
            18: e.data = a | zi12;
            19: e.data = a ^ zi12;
            20: e.data = {imm[19:0], 12'd0};
            21: e.data = cur_pc + {imm[19:0], 12'd0};
            22: begin
                e.data = cur_pc + 32'd4;
                e.taken = 1'b1;
                e.target = a + off16;
            end
            23: begin
                e.writes = 1'b0;
                e.taken = 1'b1;
                e.target = cur_pc + off26;
            end
            24: begin
                e.dest = 5'd1;
                e.data = cur_pc + 32'd4;
                e.taken = 1'b1;
                e.target = cur_pc + off26;
            end
            25: e.taken = a == c;
            26: e.taken = a != c;
            27: e.taken = $signed(a) < $signed(c);
            28: e.taken = $signed(a) >= $signed(c);
            29: e.taken = a < c;
            default: e.taken = a >= c;
        endcase
        // conditional branches never write
        if (kind >= 25) begin
            e.writes = 1'b0;
            e.target = cur_pc + off16;
        end
        if (e.dest == '0) e.writes = 1'b0;
        if (!e.taken) e.target = '0;
        return e;
    endfunction

    // hold the instruction until accepted and then retire it in the model
    task automatic issue_inst(input int kind, input int rd, input int rj, input int rk,
                              input int imm);
        la32r_pkg::reg_addr_t d, j, k;
        logic [25:0]          f;
        d = 5'(rd);
        j = 5'(rj);
        k = 5'(rk);
        f = 26'(imm);
        @(posedge clk);
        #2;
        inst_i = encode_inst(kind, d, j, k, f);
        pc_i = pc;
        inst_valid_i = 1'b1;
        cur_exp = model_step(kind, d, j, k, f, pc);
        @(negedge clk);
        while (!inst_accept_o) @(negedge clk);
        if (cur_exp.writes) arch_rf[cur_exp.dest] = cur_exp.data;
        pc = cur_exp.taken ? cur_exp.target : pc + 32'd4;
        issued++;
    endtask

    // sampled mid cycle where outputs have settled
    always @(negedge clk) begin
        if (!reset_i) begin
            if (inst_accept_o) begin
                assert (inst_valid_i)
                    else stop_with_error("inst_accept_o is high without inst_valid_i");
                assert (branch_taken_o == cur_exp.taken)
                    else report_mismatch("branch_taken_o", 32'(branch_taken_o),
                                         32'(cur_exp.taken));
                assert (branch_target_o == cur_exp.target)
                    else report_mismatch("branch_target_o", branch_target_o, cur_exp.target);
                if (cur_exp.writes) begin
                    wb_q.push_back(cur_exp);
                    due_q.push_back(cycle + 2);
                end
            end else begin
                assert (!branch_taken_o)
                    else stop_with_error("branch_taken_o is high without an accept");
                assert (branch_target_o == 32'd0)
                    else report_mismatch("branch_target_o", branch_target_o, 32'd0);
            end
            if (wb_valid_o) begin
                assert (wb_q.size() > 0)
                    else stop_with_error("wb_valid_o is high with no writeback expected");
                wb_head = wb_q.pop_front();
                wb_due = due_q.pop_front();
                assert (wb_addr_o == wb_head.dest)
                    else report_mismatch("wb_addr_o", 32'(wb_addr_o), 32'(wb_head.dest));
                assert (wb_data_o == wb_head.data)
                    else report_mismatch("wb_data_o", wb_data_o, wb_head.data);
                assert (cycle == wb_due)
                    else report_mismatch("writeback cycle", 32'(cycle), 32'(wb_due));
            end
            // a head past its slot was lost
            if (due_q.size() > 0) begin
                assert (due_q[0] >= cycle)
                    else stop_with_error("an expected writeback never appeared");
            end
        end
    end

    initial begin
        #watchdog_time;
        stop_with_error("timeout, the pipeline stopped accepting or draining");
    end

    initial begin
        int kind;
        int rk;
        reset_i = 1'b1;
        inst_valid_i = 1'b0;
        inst_i = '0;
        pc_i = '0;
        pc = 32'h1c00_0000;
        lfsr_state = 32'h4fef;
        cur_exp = '0;
        for (int i = 0; i < 32; i++) begin
            arch_rf[i] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        reset_i = 1'b0;
        @(negedge clk);
        assert (!inst_accept_o) else report_mismatch("inst_accept_o", 32'(inst_accept_o), 0);
        assert (!branch_taken_o)
            else report_mismatch("branch_taken_o", 32'(branch_taken_o), 0);
        assert (!wb_valid_o) else report_mismatch("wb_valid_o", 32'(wb_valid_o), 0);

        // build r2 as min, r3 as all ones and r4 as max back to back
        issue_inst(20, 2, 0, 0, 'h80000);
        issue_inst(16, 3, 0, 0, 'hfff);
        issue_inst(20, 4, 0, 0, 'h7ffff);
        issue_inst(18, 4, 4, 0, 'hfff);
        // signed vs unsigned on the boundaries
        issue_inst(2, 5, 2, 4, 0);
        issue_inst(3, 6, 2, 4, 0);
        issue_inst(2, 7, 3, 0, 0);
        issue_inst(3, 5, 0, 3, 0);
        issue_inst(15, 6, 0, 0, 'hfff);
        issue_inst(14, 7, 2, 0, 'h7ff);
        // zero-extended logic and sign-extended add
        issue_inst(17, 5, 3, 0, 'h800);
        issue_inst(19, 6, 0, 0, 'hfff);
        issue_inst(16, 7, 0, 0, 'h800);
        issue_inst(10, 5, 2, 4, 0);
        issue_inst(13, 6, 2, 1, 0);
        issue_inst(11, 7, 3, 31, 0);
        issue_inst(21, 6, 0, 0, 'h12345);
        // all six conditions and then the unconditional ones
        issue_inst(25, 0, 0, 0, 'h10);
        issue_inst(26, 3, 2, 0, 'h20);
        issue_inst(27, 4, 2, 0, 'hfff0);
        issue_inst(28, 4, 2, 0, 'h8);
        issue_inst(29, 2, 4, 0, 'h4);
        issue_inst(30, 3, 0, 0, 'h4);
        issue_inst(24, 0, 0, 0, 'h3fffffe);
        issue_inst(23, 0, 0, 0, 'h40);
        issue_inst(22, 7, 4, 0, 'hfffc);

        // random mix over a small register set for frequent hazards
        while (issued < num_insts) begin
            kind = int'(take_bits(5) % 31);
            rk = (kind >= 11 && kind <= 13) ? int'(take_bits(5)) : int'(take_bits(3));
            issue_inst(kind, int'(take_bits(3)), int'(take_bits(3)), rk,
                       int'(take_bits(26)));
        end

        @(posedge clk);
        #2;
        inst_valid_i = 1'b0;
        while (wb_q.size() != 0) @(negedge clk);
        // a few idle cycles catch any stray writeback
        repeat (4) @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- la32r_core.f
design/la32r_pkg.sv
design/la32r_decode.sv
design/la32r_execute.sv
design/la32r_writeback.sv
design/la32r_core.sv
sim/la32r_core_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        ?= la32r_core_tb
FILELIST   ?= la32r_core.f
BUILD_DIR  ?= obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run build lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	@out="$$($(BUILD_DIR)/V$(TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
